// ==== axi_bus_pkg.sv ====
package axi_bus_pkg;

    // ID seen by a master
    localparam int AXI_ID_BITS = 4;

    // Upper ID field naming the issuing master
    localparam int AXI_MASTER_BITS = 2;

    // Extended ID carried on the slave side
    localparam int AXI_IDS_BITS = AXI_ID_BITS + AXI_MASTER_BITS;

    localparam int AXI_RESP_BITS = 2;

    typedef enum logic [AXI_RESP_BITS-1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    // Beat as returned by a slave
    typedef struct packed {
        logic [AXI_IDS_BITS-1:0] ids;
        resp_e                   resp;
    } b_slv_beat_t;

    // Beat as delivered to a master
    typedef struct packed {
        logic [AXI_ID_BITS-1:0] id;
        resp_e                  resp;
    } b_mst_beat_t;

endpackage

// ==== axi_map_pkg.sv ====
package axi_map_pkg;

    // Master field codes, 3 is never issued
    typedef enum logic [axi_bus_pkg::AXI_MASTER_BITS-1:0] {
        MST_NONE = 2'd0,
        MST_M1   = 2'd1,
        MST_M2   = 2'd2
    } master_e;

    localparam int AXI_MASTER_NUM = 2;

    // S0..S2 at 0..2, default slave at 3
    localparam int AXI_SLAVE_NUM = 4;

    localparam int AXI_SLAVE_IDX_BITS = $clog2(AXI_SLAVE_NUM);

    typedef enum logic {
        ARB_IDLE = 1'b0,
        ARB_LOCK = 1'b1
    } arb_state_e;

endpackage

// ==== b_resp_slice.sv ====
`timescale 1ns/1ps

module b_resp_slice #(
    parameter int DATA_W = 8
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic [DATA_W-1:0] in_data_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    output logic [DATA_W-1:0] out_data_o,
    output logic              out_valid_o,
    input  logic              out_ready_i
);

    logic [DATA_W-1:0] skid_data;
    logic              skid_valid;
    logic              out_load;
    logic              in_hs;

    // Ready comes straight from a flop
    assign in_ready_o = ~skid_valid;
    assign in_hs      = in_valid_i & in_ready_o;

    // Main register empty or being drained
    assign out_load = out_ready_i | ~out_valid_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
            skid_valid  <= 1'b0;
        end else if (out_load) begin
            out_valid_o <= skid_valid | in_hs;
            skid_valid  <= 1'b0;
        end else if (in_hs) begin
            skid_valid <= 1'b1;
        end
    end

    // Skid entry is older, so it goes out first
    always_ff @(posedge clk) begin
        if (out_load) begin
            if (skid_valid) begin
                out_data_o <= skid_data;
            end else if (in_hs) begin
                out_data_o <= in_data_i;
            end
        end else if (in_hs) begin
            skid_data <= in_data_i;
        end
    end

endmodule

// ==== b_slave_arb.sv ====
`timescale 1ns/1ps

module b_slave_arb (
    input  logic                                      clk,
    input  logic                                      rst_n_i,
    input  axi_bus_pkg::b_slv_beat_t                  req_beat_i [axi_map_pkg::AXI_SLAVE_NUM],
    input  logic [axi_map_pkg::AXI_SLAVE_NUM-1:0]     req_valid_i,
    output logic [axi_map_pkg::AXI_SLAVE_NUM-1:0]     req_ready_o,
    output axi_bus_pkg::b_slv_beat_t                  sel_beat_o,
    output logic                                      sel_valid_o,
    input  logic                                      sel_ready_i
);

    import axi_map_pkg::*;

    arb_state_e                    state_q;
    logic [AXI_SLAVE_IDX_BITS-1:0] ptr_q;
    logic [AXI_SLAVE_IDX_BITS-1:0] lock_q;
    logic [AXI_SLAVE_IDX_BITS-1:0] scan_idx;
    logic [AXI_SLAVE_IDX_BITS-1:0] grant;
    logic [AXI_SLAVE_IDX_BITS-1:0] next_ptr;
    logic                          scan_hit;
    logic                          hs;

    // First valid slice at or after the pointer
    always_comb begin
        int cand;
        scan_idx = ptr_q;
        scan_hit = 1'b0;
        for (int i = 0; i < AXI_SLAVE_NUM; i++) begin
            cand = (int'(ptr_q) + i) % AXI_SLAVE_NUM;
            if (!scan_hit && req_valid_i[cand]) begin
                scan_idx = AXI_SLAVE_IDX_BITS'(cand);
                scan_hit = 1'b1;
            end
        end
    end

    assign grant = (state_q == ARB_LOCK) ? lock_q : scan_idx;

    // Without a hit, grant sits on an idle slice
    assign sel_valid_o = req_valid_i[grant];
    assign sel_beat_o  = req_beat_i[grant];
    assign hs          = sel_valid_o & sel_ready_i;

    always_comb begin
        req_ready_o        = '0;
        req_ready_o[grant] = hs;
    end

    assign next_ptr = (grant == AXI_SLAVE_IDX_BITS'(AXI_SLAVE_NUM - 1)) ?
                      '0 : grant + 1'b1;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ARB_IDLE;
            ptr_q   <= '0;
            lock_q  <= '0;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    // Stalled beat keeps its slot
                    if (sel_valid_o && !sel_ready_i) begin
                        state_q <= ARB_LOCK;
                        lock_q  <= grant;
                    end
                end
                ARB_LOCK: begin
                    if (hs) begin
                        state_q <= ARB_IDLE;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
            if (hs) begin
                ptr_q <= next_ptr;
            end
        end
    end

endmodule

// ==== b_master_route.sv ====
`timescale 1ns/1ps

module b_master_route (
    input  axi_bus_pkg::b_slv_beat_t                   in_beat_i,
    input  logic                                       in_valid_i,
    output logic                                       in_ready_o,
    output axi_bus_pkg::b_mst_beat_t                   out_beat_o [axi_map_pkg::AXI_MASTER_NUM],
    output logic [axi_map_pkg::AXI_MASTER_NUM-1:0]     out_valid_o,
    input  logic [axi_map_pkg::AXI_MASTER_NUM-1:0]     out_ready_i
);

    import axi_bus_pkg::*;
    import axi_map_pkg::*;

    master_e master;

    assign master = master_e'(in_beat_i.ids[AXI_IDS_BITS-1:AXI_ID_BITS]);

    // Masters only see their own ID bits
    always_comb begin
        for (int m = 0; m < AXI_MASTER_NUM; m++) begin
            out_beat_o[m].id   = in_beat_i.ids[AXI_ID_BITS-1:0];
            out_beat_o[m].resp = in_beat_i.resp;
        end
    end

    // M1 on port 0, M2 on port 1
    always_comb begin
        out_valid_o = '0;
        in_ready_o  = 1'b1;
        case (master)
            MST_M1: begin
                out_valid_o[0] = in_valid_i;
                in_ready_o     = out_ready_i[0];
            end
            MST_M2: begin
                out_valid_o[1] = in_valid_i;
                in_ready_o     = out_ready_i[1];
            end
            // No such master, beat is swallowed
            default: begin
                out_valid_o = '0;
                in_ready_o  = 1'b1;
            end
        endcase
    end

endmodule

// ==== b_ch.sv ====
`timescale 1ns/1ps

module b_ch (
    input  logic                                   clk,
    input  logic                                   rst_n_i,
    input  axi_bus_pkg::b_slv_beat_t               s_beat_i [axi_map_pkg::AXI_SLAVE_NUM],
    input  logic [axi_map_pkg::AXI_SLAVE_NUM-1:0]  s_valid_i,
    output logic [axi_map_pkg::AXI_SLAVE_NUM-1:0]  s_ready_o,
    output axi_bus_pkg::b_mst_beat_t               m_beat_o [axi_map_pkg::AXI_MASTER_NUM],
    output logic [axi_map_pkg::AXI_MASTER_NUM-1:0] m_valid_o,
    input  logic [axi_map_pkg::AXI_MASTER_NUM-1:0] m_ready_i
);

    import axi_bus_pkg::*;
    import axi_map_pkg::*;

    b_slv_beat_t               slc_beat [AXI_SLAVE_NUM];
    logic [AXI_SLAVE_NUM-1:0]  slc_valid;
    logic [AXI_SLAVE_NUM-1:0]  slc_ready;
    b_slv_beat_t               sel_beat;
    logic                      sel_valid;
    logic                      sel_ready;
    b_mst_beat_t               rt_beat [AXI_MASTER_NUM];
    logic [AXI_MASTER_NUM-1:0] rt_valid;
    logic [AXI_MASTER_NUM-1:0] rt_ready;

    // Registered input stage per slave port
    for (genvar i = 0; i < AXI_SLAVE_NUM; i++) begin : g_s_slice
        b_resp_slice #(
            .DATA_W ($bits(b_slv_beat_t))
        ) u_s_slice (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .in_data_i   (s_beat_i[i]),
            .in_valid_i  (s_valid_i[i]),
            .in_ready_o  (s_ready_o[i]),
            .out_data_o  (slc_beat[i]),
            .out_valid_o (slc_valid[i]),
            .out_ready_i (slc_ready[i])
        );
    end

    b_slave_arb u_arb (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_beat_i  (slc_beat),
        .req_valid_i (slc_valid),
        .req_ready_o (slc_ready),
        .sel_beat_o  (sel_beat),
        .sel_valid_o (sel_valid),
        .sel_ready_i (sel_ready)
    );

    b_master_route u_route (
        .in_beat_i   (sel_beat),
        .in_valid_i  (sel_valid),
        .in_ready_o  (sel_ready),
        .out_beat_o  (rt_beat),
        .out_valid_o (rt_valid),
        .out_ready_i (rt_ready)
    );

    // Output stage per master
    for (genvar m = 0; m < AXI_MASTER_NUM; m++) begin : g_m_slice
        b_resp_slice #(
            .DATA_W ($bits(b_mst_beat_t))
        ) u_m_slice (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .in_data_i   (rt_beat[m]),
            .in_valid_i  (rt_valid[m]),
            .in_ready_o  (rt_ready[m]),
            .out_data_o  (m_beat_o[m]),
            .out_valid_o (m_valid_o[m]),
            .out_ready_i (m_ready_i[m])
        );
    end

endmodule

// ==== b_ch_chk.sv ====
`timescale 1ns/1ps

module b_ch_chk (
    input logic                                   clk,
    input logic                                   rst_n_i,
    input axi_bus_pkg::b_mst_beat_t               m_beat_o [axi_map_pkg::AXI_MASTER_NUM],
    input logic [axi_map_pkg::AXI_MASTER_NUM-1:0] m_valid_o,
    input logic [axi_map_pkg::AXI_MASTER_NUM-1:0] m_ready_i
);

    import axi_map_pkg::*;

    int unsigned fail_cnt = 0;

    // Nothing leaves the channel while reset is held
    a_reset_quiet: assert property (@(posedge clk) !rst_n_i |-> m_valid_o == '0)
        else begin
            fail_cnt++;
            $error("m_valid_o raised during reset");
        end

    // A stalled beat stays put until the master takes it
    for (genvar m = 0; m < AXI_MASTER_NUM; m++) begin : g_hold
        a_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
            m_valid_o[m] && !m_ready_i[m] |=> m_valid_o[m] && $stable(m_beat_o[m]))
            else begin
                fail_cnt++;
                $error("beat at master port %0d changed while stalled", m);
            end
    end

    // Only one beat per cycle enters the master slices
    a_one_master: assert property (@(posedge clk) disable iff (!rst_n_i)
        !($rose(m_valid_o[0]) && $rose(m_valid_o[1])))
        else begin
            fail_cnt++;
            $error("both master valids rose on the same edge");
        end

endmodule

bind b_ch b_ch_chk u_chk (.*);

// ==== b_ch_tb.sv ====
`timescale 1ns/1ps

module b_ch_tb;

    import axi_bus_pkg::*;
    import axi_map_pkg::*;

    // One table row, dst is the expected master port, 2 means dropped
    typedef struct packed {
        logic [1:0] phase;
        logic [1:0] slave;
        logic [1:0] mst;
        logic [3:0] id;
        resp_e      resp;
        logic [1:0] dst;
        logic [7:0] gap;
    } stim_t;

    typedef struct packed {
        b_mst_beat_t beat;
        logic [31:0] acc_cyc;
    } exp_t;

    logic                      clk = 1'b0;
    logic                      rst_n;
    b_slv_beat_t               s_beat [AXI_SLAVE_NUM] = '{default: '0};
    logic [AXI_SLAVE_NUM-1:0]  s_valid = '0;
    logic [AXI_SLAVE_NUM-1:0]  s_ready;
    b_mst_beat_t               m_beat [AXI_MASTER_NUM];
    logic [AXI_MASTER_NUM-1:0] m_valid;
    logic [AXI_MASTER_NUM-1:0] m_ready = '1;

    stim_t                    tbl [$];
    stim_t                    pend_q [AXI_SLAVE_NUM][$];
    stim_t                    cur [AXI_SLAVE_NUM];
    exp_t                     exp_q [AXI_MASTER_NUM][AXI_SLAVE_NUM][$];
    int                       acc_cnt [AXI_SLAVE_NUM] = '{default: 0};
    int                       sent_cnt [AXI_SLAVE_NUM] = '{default: 0};
    logic [AXI_SLAVE_NUM-1:0] round_mask = '0;
    logic [1:0]               phase = 2'd0;
    integer                   seed = 32'hfc4d;
    int                       cyc = 0;
    int                       limit = 1000;
    int                       err_cnt = 0;
    int                       chk_cnt = 0;
    int                       accepted = 0;
    int                       delivered = 0;

    b_ch UUT (
        .clk       (clk),
        .rst_n_i   (rst_n),
        .s_beat_i  (s_beat),
        .s_valid_i (s_valid),
        .s_ready_o (s_ready),
        .m_beat_o  (m_beat),
        .m_valid_o (m_valid),
        .m_ready_i (m_ready)
    );

    always #10 clk = ~clk;

    task automatic check_val(input logic [31:0] got, input logic [31:0] want,
                             input string what);
        chk_cnt++;
        if (got !== want) begin
            err_cnt++;
            $display("ERROR %0t ns: %s is %0h, expected %0h", $time, what, got, want);
        end
    endtask

    task automatic add_stim(input logic [1:0] ph, input int slv, input logic [1:0] mst,
                            input int seq, input resp_e resp, input int gap);
        stim_t e;
        e.phase = ph;
        e.slave = 2'(slv);
        e.mst   = mst;
        e.id    = {2'(slv), 2'(seq)};
        e.resp  = resp;
        // M1 sits on port 0, M2 on port 1, anything else vanishes
        e.dst   = (mst == MST_M1) ? 2'd0 : (mst == MST_M2) ? 2'd1 : 2'd2;
        e.gap   = 8'(gap);
        tbl.push_back(e);
    endtask

    task automatic build_table();
        int rnd;
        add_stim(1, 0, MST_M1, 0, RESP_OKAY, 6);
        add_stim(1, 1, MST_M2, 1, RESP_EXOKAY, 6);
        add_stim(1, 2, MST_M1, 2, RESP_SLVERR, 6);
        add_stim(1, 3, MST_M2, 3, RESP_DECERR, 6);
        add_stim(1, 2, MST_NONE, 3, RESP_OKAY, 6);
        add_stim(1, 1, 2'd3, 2, RESP_SLVERR, 6);
        add_stim(1, 0, MST_M2, 1, RESP_SLVERR, 6);
        add_stim(1, 3, MST_M1, 0, RESP_DECERR, 6);
        // Every slave at once, two beats each
        for (int j = 0; j < 2; j++) begin
            for (int s = 0; s < AXI_SLAVE_NUM; s++) begin
                add_stim(2, s, MST_M1, j, resp_e'(2'(s + j)), 0);
            end
        end
        for (int k = 0; k < 28; k++) begin
            rnd = $random(seed);
            add_stim(3, rnd & 3, 2'((rnd >> 2) & 3), k, resp_e'(2'(rnd >> 4)), (rnd >> 6) & 3);
        end
    endtask

    task automatic wait_drain();
        logic busy;
        busy = 1'b1;
        while (busy) begin
            @(posedge clk);
            busy = (s_valid != '0);
            for (int s = 0; s < AXI_SLAVE_NUM; s++) begin
                if (pend_q[s].size() != 0) busy = 1'b1;
                for (int m = 0; m < AXI_MASTER_NUM; m++) begin
                    if (exp_q[m][s].size() != 0) busy = 1'b1;
                end
            end
        end
    endtask

    // Slave bus models and master ready
    always @(negedge clk) begin
        if (rst_n) begin
            for (int s = 0; s < AXI_SLAVE_NUM; s++) begin
                if (s_valid[s] && acc_cnt[s] == sent_cnt[s]) begin
                    s_valid[s] = 1'b0;
                end
                if (!s_valid[s] && pend_q[s].size() != 0) begin
                    cur[s] = pend_q[s].pop_front();
                    s_beat[s].ids  = {cur[s].mst, cur[s].id};
                    s_beat[s].resp = cur[s].resp;
                    s_valid[s] = 1'b1;
                    sent_cnt[s]++;
                end
            end
            m_ready = (phase == 2'd3) ? 2'($random(seed)) : '1;
        end
    end

    // Scoreboard on both sides of the channel
    always @(posedge clk) begin
        exp_t x;
        int   s;
        for (int i = 0; i < AXI_SLAVE_NUM; i++) begin
            if (rst_n && s_valid[i] && s_ready[i]) begin
                acc_cnt[i]++;
                accepted++;
                if (cur[i].dst != 2'd2) begin
                    x.beat.id   = cur[i].id;
                    x.beat.resp = cur[i].resp;
                    x.acc_cyc   = cyc;
                    exp_q[cur[i].dst][i].push_back(x);
                end
            end
        end
        for (int m = 0; m < AXI_MASTER_NUM; m++) begin
            if (rst_n && m_valid[m] && m_ready[m]) begin
                s = int'(m_beat[m].id[3:2]);
                delivered++;
                if (exp_q[m][s].size() == 0) begin
                    err_cnt++;
                    $display("Master port %0d got ID %0h that no slave sent to it", m,
                             m_beat[m].id);
                end else begin
                    x = exp_q[m][s].pop_front();
                    check_val(m_beat[m], x.beat, "beat at master port");
                    if (phase == 2'd1) check_val(cyc - x.acc_cyc, 2, "latency");
                    if (phase == 2'd2) begin
                        if (round_mask[s]) begin
                            err_cnt++;
                            $display("Slave %0d got a second turn before the others", s);
                        end
                        round_mask[s] = 1'b1;
                        if (round_mask == '1) round_mask = '0;
                    end
                end
            end
        end
        cyc++;
        if (cyc >= limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        int sum;
        int known;
        sum   = 0;
        known = 0;
        rst_n = 1'b1;
        build_table();
        foreach (tbl[k]) begin
            sum += tbl[k].gap;
            if (tbl[k].dst != 2'd2) known++;
        end
        limit = 4 * sum + 200;
        #2 rst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_val(m_valid, 0, "m_valid_o after reset");
        check_val(s_ready, 4'hf, "s_ready_o after reset");
        @(posedge clk);
        foreach (tbl[k]) begin
            if (tbl[k].phase != phase) begin
                wait_drain();
                phase = tbl[k].phase;
            end
            pend_q[tbl[k].slave].push_back(tbl[k]);
            repeat (tbl[k].gap) @(posedge clk);
        end
        wait_drain();
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_val(m_valid, 0, "m_valid_o after the last beat");
        check_val(accepted, tbl.size(), "beats accepted at slave ports");
        check_val(delivered, known, "beats delivered to masters");
        err_cnt += UUT.u_chk.fail_cnt;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", chk_cnt, err_cnt,
                 UUT.u_chk.fail_cnt);
        if (err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== b_ch.f ====
axi_bus_pkg.sv
axi_map_pkg.sv
b_resp_slice.sv
b_slave_arb.sv
b_master_route.sv
b_ch.sv
b_ch_chk.sv
b_ch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the B channel testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -Wno-fatal --top-module b_ch_tb \
    -f b_ch.f -o b_ch_sim &&
./obj_dir/b_ch_sim +verilator+error+limit+1000 | tee /dev/stderr |
    grep -q "Everything OK" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
